//--- dv/adpcmb_checker.sv
// reference model and comparator for adpcmb_top; assumes restart and din_we never land on cen55.
`timescale 1ns/1ps

module adpcmb_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen55,
    input  logic               restart,
    input  logic [7:0]         din,
    input  logic               din_we,
    input  logic [7:0]         tl,
    input  logic               req,
    input  logic signed [15:0] pcm_out,
    output int                 n_checks,
    output int                 n_errors
);

    logic [3:0] nib_q [$];   // nibbles not yet decoded.
    int         acc_m;       // model sample.
    int         step_m;      // model step size.
    int         res_m;       // attenuated sample, out on next strobe.
    int         expect_m;
    logic       check_due;   // compare one cycle after a strobe.
    logic       req_due;     // byte used up, or restart.

    // ------------------------------
    // model rules
    // ------------------------------
    function automatic int clamp(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    // accumulator first with the old step, then step adaptation.
    function automatic void decode_nibble(input logic [3:0] n);
        int delta;
        delta  = (step_m * (2 * int'(n[2:0]) + 1)) / 8;
        acc_m  = n[3] ? acc_m - delta : acc_m + delta;
        acc_m  = clamp(acc_m, -32768, 32767);
        step_m = clamp(step_m * int'(adpcmb_pkg::step_factor[n[2:0]]) / 64,
                       int'(adpcmb_pkg::step_min), int'(adpcmb_pkg::step_max));
    endfunction

    // fine factor over 512, then coarse shift by the inverted top bits.
    function automatic int attenuate(input int s, input logic [7:0] lvl);
        int prod;
        prod = int'(adpcmb_pkg::gain_table[~lvl[2:0]]) * s;
        return (prod >>> 9) >>> (~lvl[7:3]);
    endfunction

    // ------------------------------
    // watch and compare
    // ------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            nib_q.delete();
            acc_m     = 0;
            step_m    = int'(adpcmb_pkg::step_min);
            res_m     = 0;
            expect_m  = 0;
            check_due = 1'b0;
            req_due   = 1'b0;
            n_checks  = 0;
            n_errors  = 0;
        end else begin
            if (check_due) begin
                n_checks++;
                if (int'(pcm_out) == expect_m) begin
                    $display("check %0d ok, pcm_out = %0d", n_checks, pcm_out);
                end else begin
                    n_errors++;
                    $display("FAILED at %0t: pcm_out = %0d, expected %0d",
                             $time, pcm_out, expect_m);
                end
            end
            if (req_due != req) begin
                n_errors++;
                if (req_due) begin
                    $display("no byte request at %0t after a byte was used up", $time);
                end else begin
                    $display("byte request at %0t while a byte was still pending", $time);
                end
            end
            check_due = 1'b0;
            req_due   = 1'b0;
            if (cen55) begin
                expect_m  = res_m;               // result of the last capture.
                check_due = 1'b1;
                res_m     = attenuate(acc_m, tl);  // sample before this nibble.
                if (nib_q.size() != 0 && !restart) begin
                    decode_nibble(nib_q.pop_front());
                    req_due = (nib_q.size() == 0);
                end
            end
            if (restart) begin
                nib_q.delete();
                acc_m   = 0;                     // back to silence.
                step_m  = int'(adpcmb_pkg::step_min);
                req_due = 1'b1;
            end else if (din_we) begin
                nib_q.delete();                  // overwrite starts high.
                nib_q.push_back(din[7:4]);
                nib_q.push_back(din[3:0]);
                req_due = 1'b0;
            end
        end
    end

endmodule

//--- dv/tb_adpcmb.sv
// testbench for adpcmb_top; cen55 every 64 clk, one stimulus row per requested byte.
`timescale 1ns/1ps

module tb_adpcmb;

    typedef struct packed {
        logic [7:0] data;         // adpcm byte.
        logic [7:0] level;        // tl while this byte plays.
        logic       do_restart;   // restart before the byte.
        logic       gap;          // one empty strobe before the byte.
    } row_t;

    logic clk, rst_n, cen55, restart, din_we, req;
    logic [7:0] din, tl;
    logic signed [15:0] pcm_out;
    int   n_checks, n_errors, cycles, limit, strobe_cnt;
    row_t rows [$];

    adpcmb_top UUT (
        .clk(clk), .rst_n(rst_n), .cen55(cen55), .restart(restart), .din(din),
        .din_we(din_we), .tl(tl), .req(req), .pcm_out(pcm_out)
    );

    adpcmb_checker u_checker (
        .clk(clk), .rst_n(rst_n), .cen55(cen55), .restart(restart), .din(din),
        .din_we(din_we), .tl(tl), .req(req), .pcm_out(pcm_out),
        .n_checks(n_checks), .n_errors(n_errors)
    );

    // ------------------------------
    // clock, strobe, timeout
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles     <= cycles + 1;
        strobe_cnt <= (strobe_cnt == 63) ? 0 : strobe_cnt + 1;
        cen55      <= (strobe_cnt == 63);   // one cycle in 64.
    end

    initial begin
        @(posedge clk);
        while (cycles < limit) @(posedge clk);
        $display("timeout after %0d cycles, DUT stopped requesting bytes", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    task automatic add_row(input logic [7:0] d, input logic [7:0] l, input logic r,
                           input logic g);
        rows.push_back(row_t'{data: d, level: l, do_restart: r, gap: g});
    endtask

    function automatic logic [7:0] rand_byte();
        int r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic wait_strobe();
        @(posedge clk);
        while (!cen55) @(posedge clk);
    endtask

    task automatic wait_req();
        @(posedge clk);
        while (!req) @(posedge clk);
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        din    <= r.data;
        tl     <= r.level;
        din_we <= 1'b1;
        @(posedge clk);
        din_we <= 1'b0;
    endtask

    task automatic build_table();
        add_row(8'h13, 8'hff, 1'b0, 1'b0);            // unity gain with small positives.
        add_row(8'h24, 8'hff, 1'b0, 1'b0);
        add_row(8'h9a, 8'hff, 1'b0, 1'b0);            // negative run.
        add_row(8'hbc, 8'hff, 1'b0, 1'b0);
        for (int k = 0; k < 12; k++) add_row(8'h77, 8'hff, 1'b0, 1'b0);   // to +rail.
        for (int k = 0; k < 12; k++) add_row(8'hff, 8'hff, 1'b0, 1'b0);   // to -rail.
        for (int k = 0; k < 8; k++) add_row(8'h00, 8'hff, 1'b0, 1'b0);    // step shrinks.
        for (int k = 0; k < 8; k++) add_row(rand_byte(), {5'h1f, k[2:0]}, 1'b0, 1'b0);
        for (int k = 0; k < 32; k++) add_row(rand_byte(), {k[4:0], 3'h7}, 1'b0, 1'b0);
        add_row(8'h35, 8'hff, 1'b1, 1'b0);            // restart from silence.
        add_row(8'h4c, 8'hff, 1'b0, 1'b1);            // underflow gap.
        add_row(8'hd2, 8'hfc, 1'b1, 1'b0);
        add_row(8'h61, 8'hff, 1'b0, 1'b1);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_n      = 1'b0;
        restart    = 1'b0;
        cen55      = 1'b0;
        din        = 8'h00;
        din_we     = 1'b0;
        tl         = 8'hff;
        cycles     = 0;
        strobe_cnt = 0;
        void'($urandom(32'hbd0f));
        build_table();
        limit = rows.size() * 2 * 64 + 500;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait_strobe();                             // first byte lines up after a strobe.
        foreach (rows[i]) begin
            if (rows[i].do_restart) begin
                @(posedge clk);
                restart <= 1'b1;
                @(posedge clk);
                restart <= 1'b0;
                wait_req();
            end
            if (rows[i].gap) begin
                wait_strobe();                     // strobe on an empty buffer.
            end
            apply_row(rows[i]);
            wait_req();                            // both nibbles used.
        end
        repeat (3) wait_strobe();                  // drain the two-strobe pipeline.
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_adpcmb -f verilog.f &&
./obj_dir/Vtb_adpcmb | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run ok" ||
{ echo "run did not pass"; exit 1; }

//--- src/adpcmb_decoder.sv
// adpcm-b accumulator and step adaptation; one nibble per nib_valid, result one clk later.
`timescale 1ns/1ps

module adpcmb_decoder (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  restart,
    input  logic [3:0]                            nibble,
    input  logic                                  nib_valid,
    output logic signed [adpcmb_pkg::pcm_w-1:0]   dec_pcm
);

    logic [adpcmb_pkg::pcm_w-1:0] step_q;   // current step size.

    // ------------------------------
    // delta from step and magnitude
    // ------------------------------
    logic [2:0]  mag;          // nibble magnitude.
    logic [3:0]  odd_mult;     // 2*mag + 1.
    logic [19:0] delta_full;   // step * (2*mag+1).
    logic [16:0] delta;        // divided by 8.

    assign mag        = nibble[2:0];
    assign odd_mult   = {mag, 1'b1};
    assign delta_full = step_q * odd_mult;
    assign delta      = delta_full[19:3];   // truncating divide.

    // ------------------------------
    // accumulator with saturation
    // ------------------------------
    logic signed [17:0]                   acc_ext;   // room for one carry.
    logic signed [17:0]                   delta_s;
    logic signed [17:0]                   sum;
    logic signed [adpcmb_pkg::pcm_w-1:0]  acc_next;

    assign acc_ext = dec_pcm;                  // sign extends.
    assign delta_s = $signed({1'b0, delta});

    always_comb begin
        // bit 3 is the sign.
        if (nibble[3]) begin
            sum = acc_ext - delta_s;
        end else begin
            sum = acc_ext + delta_s;
        end
        if (sum > 18'sd32767) begin
            acc_next = 16'sh7fff;              // positive rail.
        end else if (sum < -18'sd32768) begin
            acc_next = 16'sh8000;              // negative rail.
        end else begin
            acc_next = sum[15:0];
        end
    end

    // ------------------------------
    // step adaptation
    // ------------------------------
    logic [23:0]                   step_prod;   // step * factor.
    logic [17:0]                   step_div;    // divided by 64.
    logic [adpcmb_pkg::pcm_w-1:0]  step_next;

    assign step_prod = step_q * adpcmb_pkg::step_factor[mag];
    assign step_div  = step_prod[23:6];

    always_comb begin
        if (step_div > {2'b00, adpcmb_pkg::step_max}) begin
            step_next = adpcmb_pkg::step_max;
        end else if (step_div < {2'b00, adpcmb_pkg::step_min}) begin
            step_next = adpcmb_pkg::step_min;  // small nibbles shrink to floor.
        end else begin
            step_next = step_div[15:0];
        end
    end

    // ------------------------------
    // state
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_pcm <= '0;
            step_q  <= adpcmb_pkg::step_min;
        end else if (restart) begin
            dec_pcm <= '0;                     // decode resumes from silence.
            step_q  <= adpcmb_pkg::step_min;
        end else if (nib_valid) begin
            dec_pcm <= acc_next;
            step_q  <= step_next;
        end
    end

endmodule

//--- src/adpcmb_gain.sv
// total level at 0.75 dB per step; needs max_shift+3 clk between cen55 strobes.
`timescale 1ns/1ps

module adpcmb_gain (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cen55,
    input  logic [adpcmb_pkg::tl_w-1:0]           tl,       // total level.
    input  logic signed [adpcmb_pkg::pcm_w-1:0]   pcm_in,
    output logic signed [adpcmb_pkg::pcm_w-1:0]   pcm_out
);

    logic [adpcmb_pkg::gain_w-1:0] lin_gain;   // fine factor from low bits.

    // ------------------------------
    // fine gain lookup
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lin_gain <= '0;
        end else begin
            lin_gain <= adpcmb_pkg::gain_table[~tl[2:0]];
        end
    end

    logic signed [26:0]                   pcm_mul;    // gain * sample.
    logic signed [adpcmb_pkg::pcm_w-1:0]  pcm_sh;     // slice being shifted.
    logic                                 toggle;     // flips per strobe.
    logic                                 toggle_last;

    // ------------------------------
    // strobe multiply and publish
    // ------------------------------
    always_ff @(posedge clk) begin
        if (cen55) begin
            pcm_mul <= $signed({1'b0, lin_gain}) * pcm_in;   // captured per strobe.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            toggle  <= 1'b0;
            pcm_out <= '0;
        end else if (cen55) begin
            pcm_out <= pcm_sh;          // result of previous strobe.
            toggle  <= ~toggle;
        end
    end

    // ------------------------------
    // coarse gain by serial shifter
    // ------------------------------
    logic [$clog2(adpcmb_pkg::max_shift+1)-1:0] shift_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            toggle_last <= 1'b0;
            shift_cnt   <= '0;
            pcm_sh      <= '0;
        end else begin
            toggle_last <= toggle;
            if (toggle != toggle_last) begin
                // fresh product without the 512 scale.
                pcm_sh    <= pcm_mul[24:9];
                shift_cnt <= ~tl[7:3];
            end else if (shift_cnt != '0) begin
                pcm_sh    <= pcm_sh >>> 1;          // keeps sign.
                shift_cnt <= shift_cnt - 1'b1;
            end
        end
    end

endmodule

//--- src/adpcmb_nibble_sel.sv
// one-byte buffer handing out the high nibble first; a strobe on an empty buffer yields no nibble.
`timescale 1ns/1ps

module adpcmb_nibble_sel (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen55,     // sample strobe.
    input  logic       restart,
    input  logic [7:0] din,       // adpcm byte.
    input  logic       din_we,
    output logic       req,       // asks for the next byte.
    output logic [3:0] nibble,
    output logic       nib_valid
);

    logic [7:0] byte_q;   // held byte.
    logic       full;     // byte waiting to be used.
    logic       half;     // high nibble already handed out.

    // ------------------------------
    // nibble out in the strobe cycle
    // ------------------------------
    assign nib_valid = cen55 & full & ~restart;   // restart wins.
    assign nibble    = half ? byte_q[3:0] : byte_q[7:4];

    // byte latch.
    always_ff @(posedge clk) begin
        if (din_we) begin
            byte_q <= din;
        end
    end

    // ------------------------------
    // buffer state and request
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
            half <= 1'b0;
            req  <= 1'b0;
        end else begin
            req <= 1'b0;                  // one-cycle pulse.
            if (restart) begin
                full <= 1'b0;
                half <= 1'b0;
                req  <= 1'b1;             // refill after restart.
            end else if (din_we) begin
                full <= 1'b1;             // overwrite restarts at high nibble.
                half <= 1'b0;
            end else if (cen55 && full) begin
                if (half) begin
                    // low nibble used and buffer freed.
                    full <= 1'b0;
                    half <= 1'b0;
                    req  <= 1'b1;
                end else begin
                    half <= 1'b1;         // low nibble next.
                end
            end
        end
    end

endmodule

//--- src/adpcmb_pkg.sv
// shared widths and tables for the adpcm-b path; cen55 must be at least 34 clk apart.
package adpcmb_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int pcm_w  = 16;   // signed sample width.
    localparam int tl_w   = 8;    // total level width.
    localparam int gain_w = 10;   // linear gain factor width.

    // ------------------------------
    // step size limits
    // ------------------------------
    // reset and restart value too.
    localparam logic [pcm_w-1:0] step_min = 16'd127;
    localparam logic [pcm_w-1:0] step_max = 16'd24576;   // clamp ceiling.

    // step adaptation factors per magnitude.
    // new step = old step * factor / 64.
    localparam logic [7:0] step_factor [0:7] = '{
        8'd57,
        8'd57,
        8'd57,
        8'd57,
        8'd77,
        8'd102,
        8'd128,
        8'd153
    };

    // ------------------------------
    // attenuation
    // ------------------------------
    // 0.75 dB per entry down from unity at 512.
    // indexed by the inverted low three bits of tl.
    localparam logic [gain_w-1:0] gain_table [0:7] = '{
        10'd512,
        10'd470,
        10'd431,
        10'd395,
        10'd362,
        10'd332,
        10'd305,
        10'd280
    };

    // longest serial shift; sets the minimum strobe spacing.
    localparam int max_shift = 31;

endpackage

//--- src/adpcmb_top.sv
// adpcm-b sample path; pcm_out lags the nibble by two cen55 strobes, no byte addressing.
`timescale 1ns/1ps

module adpcmb_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cen55,     // sample strobe.
    input  logic                                  restart,
    input  logic [7:0]                            din,       // adpcm byte.
    input  logic                                  din_we,
    input  logic [adpcmb_pkg::tl_w-1:0]           tl,        // total level.
    output logic                                  req,       // byte request.
    output logic signed [adpcmb_pkg::pcm_w-1:0]   pcm_out
);

    // ------------------------------
    // stage links
    // ------------------------------
    logic [3:0]                           nibble;
    logic                                 nib_valid;   // aligned to cen55.
    logic signed [adpcmb_pkg::pcm_w-1:0]  dec_pcm;     // held between nibbles.

    // byte buffer, nibbles high first.
    adpcmb_nibble_sel u_nibble_sel (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen55     (cen55),
        .restart   (restart),
        .din       (din),
        .din_we    (din_we),
        .req       (req),
        .nibble    (nibble),
        .nib_valid (nib_valid)
    );

    // nibble to 16-bit sample.
    adpcmb_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .restart   (restart),
        .nibble    (nibble),
        .nib_valid (nib_valid),
        .dec_pcm   (dec_pcm)
    );

    // total level attenuation.
    adpcmb_gain u_gain (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen55   (cen55),
        .tl      (tl),
        .pcm_in  (dec_pcm),
        .pcm_out (pcm_out)
    );

endmodule

//--- verilog.f
src/adpcmb_pkg.sv
src/adpcmb_nibble_sel.sv
src/adpcmb_decoder.sv
src/adpcmb_gain.sv
src/adpcmb_top.sv
dv/adpcmb_checker.sv
dv/tb_adpcmb.sv
